/* design/sw_pkg.sv */
// sizes, scoring constants and types shared by the aligner; modules import it in their bodies
package sw_pkg;

    localparam int REF_MAX_LEN  = 16;
    localparam int READ_MAX_LEN = 8;   // one cell per read base
    localparam int SCORE_W      = 10;
    localparam int COUNT_W      = $clog2(REF_MAX_LEN + READ_MAX_LEN + 1);

    typedef logic signed [SCORE_W-1:0] score_t;

    localparam score_t MATCH_SCORE    = 2;
    localparam score_t MISMATCH_SCORE = -1;
    localparam score_t GAP_OPEN       = -2;
    localparam score_t GAP_EXTEND     = -1;

    typedef logic [1:0] base_t;

    // align, insert and delete matrices of one cell
    typedef struct packed {
        score_t align;
        score_t ins;
        score_t del;
    } cell_t;

    // first base sits in the top pair
    typedef logic [2*REF_MAX_LEN-1:0]  ref_seq_t;
    typedef logic [2*READ_MAX_LEN-1:0] read_seq_t;

    typedef logic [$clog2(REF_MAX_LEN):0]    ref_len_t;   // 1-based
    typedef logic [$clog2(READ_MAX_LEN):0]   read_len_t;  // 1-based
    typedef logic [$clog2(REF_MAX_LEN)-1:0]  col_t;
    typedef logic [$clog2(READ_MAX_LEN)-1:0] row_t;
    typedef logic [COUNT_W-1:0]              count_t;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOAD,
        S_CALC,
        S_SELECT,
        S_DONE
    } sw_state_t;

endpackage

/* design/sw_ctrl_if.sv */
// phase strobes, step count and job lengths from the sequencer to the datapath blocks
`timescale 1ns/1ps

interface sw_ctrl_if;
    import sw_pkg::*;

    logic      clear;    // idle, zero delay regs and row maxima
    logic      load;     // fill reference shifter
    logic      calc;
    logic      select;   // final row scan
    count_t    step;
    ref_len_t  ref_len;
    read_len_t read_len;

    modport ctrl (
        output clear, load, calc, select, step, ref_len, read_len
    );

    modport dp (
        input clear, load, calc, select, step, ref_len, read_len
    );

endinterface

/* design/sw_ctrl.sv */
// job sequencer: accepts a job, runs load, calc and select phases, holds the result handshake
`timescale 1ns/1ps

module sw_ctrl (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_valid,
    output logic              o_ready,
    input  sw_pkg::ref_seq_t  i_ref_seq,
    input  sw_pkg::read_seq_t i_read_seq,
    input  sw_pkg::ref_len_t  i_ref_len,
    input  sw_pkg::read_len_t i_read_len,
    input  logic              i_ready,
    output logic              o_valid,
    output sw_pkg::ref_seq_t  o_ref_seq,
    output sw_pkg::read_seq_t o_read_seq,
    sw_ctrl_if.ctrl           ctl
);
    import sw_pkg::*;

    sw_state_t state;
    sw_state_t state_n;
    count_t    step_q;
    ref_len_t  ref_len_q;
    read_len_t read_len_q;
    count_t    calc_last;
    count_t    select_last;
    logic      accept;

    assign accept      = o_ready && i_valid;
    assign calc_last   = count_t'(ref_len_q) + count_t'(read_len_q) - count_t'(1);
    assign select_last = count_t'(read_len_q) - count_t'(1);

    always_comb begin
        state_n = state;
        case (state)
            S_IDLE:   state_n = i_valid ? S_LOAD : S_IDLE;
            S_LOAD:   state_n = S_CALC;
            S_CALC:   state_n = (step_q == calc_last) ? S_SELECT : S_CALC;
            S_SELECT: state_n = (step_q == select_last) ? S_DONE : S_SELECT;
            S_DONE:   state_n = i_ready ? S_IDLE : S_DONE;
            default:  state_n = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= S_IDLE;
            step_q     <= '0;
            ref_len_q  <= '0;
            read_len_q <= '0;
            o_valid    <= 1'b0;
        end else begin
            state   <= state_n;
            o_valid <= (state_n == S_DONE);
            if (accept) begin
                ref_len_q  <= i_ref_len;
                read_len_q <= i_read_len;
            end
            // counter wraps to zero at each phase end
            if ((state == S_CALC && step_q != calc_last) ||
                (state == S_SELECT && step_q != select_last)) begin
                step_q <= step_q + count_t'(1);
            end else begin
                step_q <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            o_ref_seq  <= i_ref_seq;
            o_read_seq <= i_read_seq;
        end
    end

    assign o_ready      = (state == S_IDLE);
    assign ctl.clear    = (state == S_IDLE);
    assign ctl.load     = (state == S_LOAD);
    assign ctl.calc     = (state == S_CALC);
    assign ctl.select   = (state == S_SELECT);
    assign ctl.step     = step_q;
    assign ctl.ref_len  = ref_len_q;
    assign ctl.read_len = read_len_q;

endmodule

/* design/sw_pe.sv */
// one affine-gap scoring cell of the systolic row chain; forwards the reference base downward
`timescale 1ns/1ps

module sw_pe (
    input  logic           clk,
    input  logic           rst,
    input  logic           i_a_valid,
    input  sw_pkg::base_t  i_a_base,
    input  logic           i_b_valid,
    input  sw_pkg::base_t  i_b_base,
    input  sw_pkg::cell_t  i_diag,
    input  sw_pkg::cell_t  i_top,
    input  sw_pkg::cell_t  i_left,
    output sw_pkg::cell_t  o_cell,
    output sw_pkg::score_t o_best,
    output logic           o_a_valid,
    output sw_pkg::base_t  o_a_base
);
    import sw_pkg::*;

    score_t sub;
    score_t ins_s;
    score_t del_s;
    score_t align_s;

    function automatic score_t smax(input score_t a, input score_t b);
        return (a > b) ? a : b;
    endfunction

    always_comb begin
        sub     = (i_a_base == i_b_base) ? MATCH_SCORE : MISMATCH_SCORE;
        ins_s   = smax(smax(i_top.align + GAP_OPEN, i_top.ins + GAP_EXTEND), '0);
        del_s   = smax(smax(i_left.align + GAP_OPEN, i_left.del + GAP_EXTEND), '0);
        align_s = smax(smax(i_diag.align + sub, ins_s), smax(del_s, '0));
    end

    always_comb begin
        if (i_a_valid && i_b_valid) begin
            o_cell.align = align_s;
            o_cell.ins   = ins_s;
            o_cell.del   = del_s;
        end else begin
            o_cell = i_left;   // no base pair here, carry the row along
        end
    end

    assign o_best = smax(smax(o_cell.align, o_cell.ins), smax(o_cell.del, '0));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_a_valid <= 1'b0;
        end else begin
            o_a_valid <= i_a_valid;
        end
    end

    always_ff @(posedge clk) begin
        o_a_base <= i_a_base;   // next row sees it one step later
    end

endmodule

/* design/sw_pe_array.sv */
// systolic chain of scoring cells, one per read row, with the delay registers and ref shifter
`timescale 1ns/1ps

module sw_pe_array (
    input  logic                            clk,
    input  logic                            rst,
    sw_ctrl_if.dp                           ctl,
    input  sw_pkg::ref_seq_t                i_ref_seq,
    input  sw_pkg::read_seq_t               i_read_seq,
    output sw_pkg::score_t                  o_row_best [sw_pkg::READ_MAX_LEN],
    output logic [sw_pkg::READ_MAX_LEN-1:0] o_row_active
);
    import sw_pkg::*;

    ref_seq_t shift_q;
    cell_t    cell_d  [READ_MAX_LEN];   // one step back
    cell_t    cell_dd [READ_MAX_LEN];   // two steps back
    cell_t    cell_w  [READ_MAX_LEN];
    cell_t    top_w   [READ_MAX_LEN];
    cell_t    diag_w  [READ_MAX_LEN];
    score_t   best_w  [READ_MAX_LEN];
    logic     a_valid [READ_MAX_LEN+1];
    base_t    a_base  [READ_MAX_LEN+1];

    // reference enters row 0 one base per calc step
    always_ff @(posedge clk) begin
        if (ctl.load) begin
            shift_q <= i_ref_seq;
        end else if (ctl.calc) begin
            shift_q <= shift_q << 2;
        end
    end

    assign a_valid[0] = ctl.calc && (ctl.step < count_t'(ctl.ref_len));
    assign a_base[0]  = shift_q[2*REF_MAX_LEN-1 -: 2];

    for (genvar r = 0; r < READ_MAX_LEN; r++) begin : g_row
        if (r == 0) begin : g_first
            assign top_w[r]  = '0;
            assign diag_w[r] = '0;
        end else begin : g_inner
            assign top_w[r]  = cell_d[r-1];   // row above, same column
            assign diag_w[r] = cell_dd[r-1];
        end

        assign o_row_active[r] = (ctl.read_len > read_len_t'(r));

        sw_pe i_pe (
            .clk       (clk),
            .rst       (rst),
            .i_a_valid (a_valid[r] && ctl.calc),   // valid chain drains outside calc
            .i_a_base  (a_base[r]),
            .i_b_valid (o_row_active[r]),
            .i_b_base  (i_read_seq[2*READ_MAX_LEN-1-2*r -: 2]),
            .i_diag    (diag_w[r]),
            .i_top     (top_w[r]),
            .i_left    (cell_d[r]),
            .o_cell    (cell_w[r]),
            .o_best    (best_w[r]),
            .o_a_valid (a_valid[r+1]),
            .o_a_base  (a_base[r+1])
        );
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int r = 0; r < READ_MAX_LEN; r++) begin
                cell_d[r]     <= '0;
                cell_dd[r]    <= '0;
                o_row_best[r] <= '0;
            end
        end else begin
            for (int r = 0; r < READ_MAX_LEN; r++) begin
                if (ctl.clear) begin
                    cell_d[r]     <= '0;
                    cell_dd[r]    <= '0;
                    o_row_best[r] <= '0;
                end else if (ctl.calc) begin
                    cell_d[r]     <= cell_w[r];
                    cell_dd[r]    <= cell_d[r];
                    o_row_best[r] <= best_w[r];
                end
            end
        end
    end

endmodule

/* design/sw_max_tracker.sv */
// keeps each row's best score and column during calc, then scans the rows for the result
`timescale 1ns/1ps

module sw_max_tracker (
    input  logic                            clk,
    input  logic                            rst,
    sw_ctrl_if.dp                           ctl,
    input  sw_pkg::score_t                  i_row_best [sw_pkg::READ_MAX_LEN],
    input  logic [sw_pkg::READ_MAX_LEN-1:0] i_row_active,
    output sw_pkg::score_t                  o_score,
    output sw_pkg::row_t                    o_row,
    output sw_pkg::col_t                    o_col
);
    import sw_pkg::*;

    score_t row_max [READ_MAX_LEN];
    col_t   row_col [READ_MAX_LEN];
    row_t   scan_row;

    assign scan_row = row_t'(ctl.step);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int r = 0; r < READ_MAX_LEN; r++) begin
                row_max[r] <= '0;
                row_col[r] <= '0;
            end
            o_score <= '0;
            o_row   <= '0;
            o_col   <= '0;
        end else if (ctl.clear) begin
            for (int r = 0; r < READ_MAX_LEN; r++) begin
                row_max[r] <= '0;
                row_col[r] <= '0;
            end
            o_score <= '0;
            o_row   <= '0;
            o_col   <= '0;
        end else begin
            if (ctl.calc) begin
                for (int r = 0; r < READ_MAX_LEN; r++) begin
                    // strict compare keeps the earliest column on ties
                    if (i_row_active[r] && i_row_best[r] > row_max[r]) begin
                        row_max[r] <= i_row_best[r];
                        row_col[r] <= col_t'(ctl.step - count_t'(r) - count_t'(1));
                    end
                end
            end
            if (ctl.select && row_max[scan_row] > o_score) begin
                o_score <= row_max[scan_row];   // lowest row wins ties
                o_row   <= scan_row;
                o_col   <= row_col[scan_row];
            end
        end
    end

endmodule

/* design/sw_top.sv */
// top level of the local aligner: valid/ready job in, best score with its row and column out
`timescale 1ns/1ps

module sw_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_valid,
    output logic              o_ready,
    input  sw_pkg::ref_seq_t  i_ref_seq,
    input  sw_pkg::read_seq_t i_read_seq,
    input  sw_pkg::ref_len_t  i_ref_len,
    input  sw_pkg::read_len_t i_read_len,
    input  logic              i_ready,
    output logic              o_valid,
    output sw_pkg::score_t    o_score,
    output sw_pkg::row_t      o_row,
    output sw_pkg::col_t      o_col
);
    import sw_pkg::*;

    ref_seq_t                ref_seq;
    read_seq_t               read_seq;
    score_t                  row_best [READ_MAX_LEN];
    logic [READ_MAX_LEN-1:0] row_active;

    sw_ctrl_if ctl ();

    sw_ctrl i_ctrl (
        .clk        (clk),
        .rst        (rst),
        .i_valid    (i_valid),
        .o_ready    (o_ready),
        .i_ref_seq  (i_ref_seq),
        .i_read_seq (i_read_seq),
        .i_ref_len  (i_ref_len),
        .i_read_len (i_read_len),
        .i_ready    (i_ready),
        .o_valid    (o_valid),
        .o_ref_seq  (ref_seq),
        .o_read_seq (read_seq),
        .ctl        (ctl.ctrl)
    );

    sw_pe_array i_array (
        .clk          (clk),
        .rst          (rst),
        .ctl          (ctl.dp),
        .i_ref_seq    (ref_seq),
        .i_read_seq   (read_seq),
        .o_row_best   (row_best),
        .o_row_active (row_active)
    );

    sw_max_tracker i_tracker (
        .clk          (clk),
        .rst          (rst),
        .ctl          (ctl.dp),
        .i_row_best   (row_best),
        .i_row_active (row_active),
        .o_score      (o_score),
        .o_row        (o_row),
        .o_col        (o_col)
    );

endmodule

/* bench/sw_properties.sv */
// concurrent checks on the result handshake and the sequencer FSM, bound into the aligner top
`timescale 1ns/1ps

module sw_properties (
    input logic              clk,
    input logic              rst,
    input logic              i_in_ready,    // DUT o_ready
    input logic              i_out_valid,   // DUT o_valid
    input logic              i_out_ready,   // DUT i_ready
    input sw_pkg::sw_state_t i_state,
    input sw_pkg::score_t    i_score,
    input sw_pkg::row_t      i_row,
    input sw_pkg::col_t      i_col
);
    import sw_pkg::*;

    int unsigned fail_count = 0;

    a_no_overlap: assert property (@(posedge clk) disable iff (rst)
        !(i_in_ready && i_out_valid))
        else begin
            $error("input ready and output valid high together");
            fail_count++;
        end

    a_valid_hold: assert property (@(posedge clk) disable iff (rst)
        i_out_valid && !i_out_ready |=> i_out_valid)
        else begin
            $error("output valid dropped without ready");
            fail_count++;
        end

    // result must not move while it waits for i_ready
    a_stall_stable: assert property (@(posedge clk) disable iff (rst)
        i_out_valid && !i_out_ready |=>
            $stable(i_score) && $stable(i_row) && $stable(i_col))
        else begin
            $error("score, row or column changed during stall");
            fail_count++;
        end

    a_state_legal: assert property (@(posedge clk) disable iff (rst)
        i_state inside {S_IDLE, S_LOAD, S_CALC, S_SELECT, S_DONE})
        else begin
            $error("FSM state outside its enum");
            fail_count++;
        end

endmodule

bind sw_top sw_properties i_props (
    .clk         (clk),
    .rst         (rst),
    .i_in_ready  (o_ready),
    .i_out_valid (o_valid),
    .i_out_ready (i_ready),
    .i_state     (i_ctrl.state),
    .i_score     (o_score),
    .i_row       (o_row),
    .i_col       (o_col)
);

/* bench/tb_sw_top.sv */
// testbench for the aligner top: directed and random jobs checked against a software model
`timescale 1ns/1ps

module tb_sw_top;
    import sw_pkg::*;

    localparam int NUM_JOBS    = 26;
    localparam int JOB_CYCLES  = REF_MAX_LEN + 2 * READ_MAX_LEN + 8;
    localparam int CYCLE_LIMIT = NUM_JOBS * JOB_CYCLES + 100;   // margin covers reset and stall

    logic      clk;
    logic      rst;
    logic      i_valid;
    logic      o_ready;
    ref_seq_t  i_ref_seq;
    read_seq_t i_read_seq;
    ref_len_t  i_ref_len;
    read_len_t i_read_len;
    logic      i_ready;
    logic      o_valid;
    score_t    o_score;
    row_t      o_row;
    col_t      o_col;

    logic [31:0] lfsr_q = 32'hf0d7;
    int          n_tests = 0;
    int          n_checks = 0;
    int          n_errors = 0;
    int          cycles = 0;

    sw_top i_sw_top (
        .clk        (clk),
        .rst        (rst),
        .i_valid    (i_valid),
        .o_ready    (o_ready),
        .i_ref_seq  (i_ref_seq),
        .i_read_seq (i_read_seq),
        .i_ref_len  (i_ref_len),
        .i_read_len (i_read_len),
        .i_ready    (i_ready),
        .o_valid    (o_valid),
        .o_score    (o_score),
        .o_row      (o_row),
        .o_col      (o_col)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, DUT never finished its jobs", cycles);
        $display("Result: FAILED");
        $finish;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);   // one step per bit
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic int imax(input int a, input int b);
        return (a > b) ? a : b;
    endfunction

    // Gotoh recurrences, row-major scan with strict compare for the tie-break
    task automatic sw_model(input ref_seq_t rs, input read_seq_t qs, input ref_len_t rl,
                            input read_len_t ql, output score_t sc, output row_t row,
                            output col_t col);
        int    h [READ_MAX_LEN][REF_MAX_LEN];
        int    e [READ_MAX_LEN][REF_MAX_LEN];
        int    f [READ_MAX_LEN][REF_MAX_LEN];
        int    top_h;
        int    top_e;
        int    left_h;
        int    left_f;
        int    diag_h;
        int    sub;
        int    best;
        base_t a;
        base_t b;
        best = 0;
        row  = '0;
        col  = '0;
        for (int r = 0; r < int'(ql); r++) begin
            for (int c = 0; c < int'(rl); c++) begin
                a      = rs[(2*REF_MAX_LEN-1-2*c) -: 2];
                b      = qs[(2*READ_MAX_LEN-1-2*r) -: 2];
                sub    = (a == b) ? int'(MATCH_SCORE) : int'(MISMATCH_SCORE);
                top_h  = (r > 0) ? h[r-1][c] : 0;
                top_e  = (r > 0) ? e[r-1][c] : 0;
                left_h = (c > 0) ? h[r][c-1] : 0;
                left_f = (c > 0) ? f[r][c-1] : 0;
                diag_h = (r > 0 && c > 0) ? h[r-1][c-1] : 0;
                e[r][c] = imax(imax(top_h + int'(GAP_OPEN), top_e + int'(GAP_EXTEND)), 0);
                f[r][c] = imax(imax(left_h + int'(GAP_OPEN), left_f + int'(GAP_EXTEND)), 0);
                h[r][c] = imax(imax(diag_h + sub, e[r][c]), imax(f[r][c], 0));
                if (h[r][c] > best) begin
                    best = h[r][c];
                    row  = row_t'(r);
                    col  = col_t'(c);
                end
            end
        end
        sc = score_t'(best);
    endtask

    task automatic check_score(input string name, input score_t got, input score_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERR %s got 0x%h exp 0x%h", name, got, exp);
        end
    endtask

    task automatic check_row(input string name, input row_t got, input row_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERR %s got 0x%h exp 0x%h", name, got, exp);
        end
    endtask

    task automatic check_col(input string name, input col_t got, input col_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERR %s got 0x%h exp 0x%h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERR %s got 0x%h exp 0x%h", name, got, exp);
        end
    endtask

    task automatic rand_job(output ref_seq_t rs, output read_seq_t qs,
                            output ref_len_t rl, output read_len_t ql);
        rs = ref_seq_t'(rand_bits(2 * REF_MAX_LEN));
        qs = read_seq_t'(rand_bits(2 * READ_MAX_LEN));
        rl = ref_len_t'(rand_bits(4)) + ref_len_t'(1);    // 1..16
        ql = read_len_t'(rand_bits(3)) + read_len_t'(1);  // 1..8
    endtask

    // called and returns 1 ns after a rising edge
    task automatic send_job(input ref_seq_t rs, input read_seq_t qs,
                            input ref_len_t rl, input read_len_t ql);
        logic taken;
        i_ref_seq  = rs;
        i_read_seq = qs;
        i_ref_len  = rl;
        i_read_len = ql;
        i_valid    = 1'b1;
        taken      = 1'b0;
        while (!taken) begin
            taken = o_ready;   // what the coming edge sees
            @(posedge clk);
            #1;
        end
        i_valid = 1'b0;
    endtask

    task automatic wait_result();
        while (o_valid !== 1'b1) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic release_result();
        i_ready = 1'b1;
        @(posedge clk);
        #1;
        i_ready = 1'b0;
    endtask

    task automatic check_job(input ref_seq_t rs, input read_seq_t qs, input ref_len_t rl,
                             input read_len_t ql, input score_t exp_score,
                             input row_t exp_row, input col_t exp_col);
        send_job(rs, qs, rl, ql);
        wait_result();
        check_score("o_score", o_score, exp_score);
        check_row("o_row", o_row, exp_row);
        check_col("o_col", o_col, exp_col);
        release_result();
    endtask

    task automatic model_job(input ref_seq_t rs, input read_seq_t qs,
                             input ref_len_t rl, input read_len_t ql);
        score_t exp_score;
        row_t   exp_row;
        col_t   exp_col;
        sw_model(rs, qs, rl, ql, exp_score, exp_row, exp_col);
        check_job(rs, qs, rl, ql, exp_score, exp_row, exp_col);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        n_tests++;
        if (n_errors == errs_before) begin
            $display("test %-12s ok", name);
        end else begin
            $display("test %-12s %0d errors", name, n_errors - errs_before);
        end
    endtask

    task automatic test_reset();
        int errs;
        errs = n_errors;
        check_flag("o_ready", o_ready, 1'b1);
        check_flag("o_valid", o_valid, 1'b0);
        check_score("o_score", o_score, score_t'(0));
        check_row("o_row", o_row, row_t'(0));
        check_col("o_col", o_col, col_t'(0));
        finish_test("reset", errs);
    endtask

    task automatic test_identical();
        int errs;
        errs = n_errors;
        // ACGT against ACGT
        check_job(ref_seq_t'({8'h1b, 24'h0}), read_seq_t'({8'h1b, 8'h0}),
                  ref_len_t'(4), read_len_t'(4), score_t'(8), row_t'(3), col_t'(3));
        finish_test("identical", errs);
    endtask

    task automatic test_no_common();
        int errs;
        errs = n_errors;
        check_job(ref_seq_t'(32'h0), read_seq_t'(16'h5555), ref_len_t'(8), read_len_t'(8),
                  score_t'(0), row_t'(0), col_t'(0));
        finish_test("no_common", errs);
    endtask

    task automatic test_gap();
        int errs;
        errs = n_errors;
        // ref ACGTACGT, reads ACGACGT and ACGCGT need a one and a two base gap
        model_job(ref_seq_t'({16'h1b1b, 16'h0}), read_seq_t'(16'h186c),
                  ref_len_t'(8), read_len_t'(7));
        model_job(ref_seq_t'({16'h1b1b, 16'h0}), read_seq_t'(16'h19b0),
                  ref_len_t'(8), read_len_t'(6));
        finish_test("gap", errs);
    endtask

    task automatic test_random();
        int        errs;
        ref_seq_t  rs;
        read_seq_t qs;
        ref_len_t  rl;
        read_len_t ql;
        errs = n_errors;
        for (int i = 0; i < 20; i++) begin
            rand_job(rs, qs, rl, ql);
            if (i == 0) begin
                rl = ref_len_t'(REF_MAX_LEN);
                ql = read_len_t'(READ_MAX_LEN);
            end else if (i == 1) begin
                rl = ref_len_t'(1);
                ql = read_len_t'(1);
            end
            model_job(rs, qs, rl, ql);
        end
        finish_test("random", errs);
    endtask

    task automatic test_stall();
        int        errs;
        ref_seq_t  rs;
        read_seq_t qs;
        ref_len_t  rl;
        read_len_t ql;
        score_t    exp_score;
        row_t      exp_row;
        col_t      exp_col;
        errs = n_errors;
        rand_job(rs, qs, rl, ql);
        sw_model(rs, qs, rl, ql, exp_score, exp_row, exp_col);
        send_job(rs, qs, rl, ql);
        wait_result();
        repeat (6) begin
            check_flag("o_valid", o_valid, 1'b1);
            check_flag("o_ready", o_ready, 1'b0);
            check_score("o_score", o_score, exp_score);
            check_row("o_row", o_row, exp_row);
            check_col("o_col", o_col, exp_col);
            @(posedge clk);
            #1;
        end
        release_result();
        check_flag("o_valid", o_valid, 1'b0);
        check_flag("o_ready", o_ready, 1'b1);
        rand_job(rs, qs, rl, ql);
        model_job(rs, qs, rl, ql);
        finish_test("stall", errs);
    endtask

    initial begin
        rst        = 1'b1;
        i_valid    = 1'b0;
        i_ref_seq  = '0;
        i_read_seq = '0;
        i_ref_len  = '0;
        i_read_len = '0;
        i_ready    = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset();
        test_identical();
        test_no_common();
        test_gap();
        test_random();
        test_stall();
        $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
                 n_tests, n_checks, n_errors, i_sw_top.i_props.fail_count);
        if (n_errors == 0 && i_sw_top.i_props.fail_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* compile.f */
design/sw_pkg.sv
design/sw_ctrl_if.sv
design/sw_ctrl.sv
design/sw_pe.sv
design/sw_pe_array.sv
design/sw_max_tracker.sv
design/sw_top.sv
bench/sw_properties.sv
bench/tb_sw_top.sv

/* Makefile */
# Verilator build and run of the aligner testbench

sim:
	verilator --binary --timing --assert --top-module tb_sw_top -f compile.f -o sim_tb
	./obj_dir/sim_tb +verilator+error+limit+100 | tee sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
